// File: run.sh
#!/bin/sh
# build and run the rename core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_ooo_core -f verilog.f
out=$(./obj_dir/Vtb_ooo_core)
echo "$out"
if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: src/complete_stage.sv
// single-cycle ALU into a one-entry result slot, plus CDB selection
// multiplier wins the bus; a blocked ALU result waits in its slot
// the bus itself is combinational from the slot and the multiplier
`default_nettype none

module complete_stage (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire ooo_pkg::issue_t    issue,
  input  wire logic               mul_done,
  input  wire ooo_pkg::phys_idx_t mul_tag,
  input  wire ooo_pkg::data_t     mul_result,
  output logic                    mul_grant,
  output logic                    alu_free,
  output ooo_pkg::cdb_t           cdb
);

  logic               slot_valid;
  ooo_pkg::phys_idx_t slot_tag;
  ooo_pkg::data_t     slot_value;
  logic               alu_capture;
  logic               alu_grant;
  ooo_pkg::data_t     alu_result;

  assign alu_capture = issue.valid && (issue.op != ooo_pkg::OP_MUL);

  // ADD and ADDI share the adder
  assign alu_result = (issue.op == ooo_pkg::OP_SUB) ? issue.opa - issue.opb
                                                    : issue.opa + issue.opb;

  ////////////////////////////////////////////////////////////
  // priority select
  ////////////////////////////////////////////////////////////
  assign mul_grant = mul_done;
  assign alu_grant = slot_valid && !mul_done;
  assign alu_free  = !slot_valid;

  always_comb begin
    cdb.valid = mul_done || slot_valid;
    if (mul_done) begin
      cdb.tag   = mul_tag;
      cdb.value = mul_result;
    end else begin
      cdb.tag   = slot_tag;
      cdb.value = slot_value;
    end
  end

  // slot occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= 1'b0;
    end else if (alu_capture) begin
      slot_valid <= 1'b1;
    end else if (alu_grant) begin
      slot_valid <= 1'b0;
    end
  end

  // slot payload
  always_ff @(posedge clock) begin
    if (alu_capture) begin
      slot_tag   <= issue.tag;
      slot_value <= alu_result;
    end
  end

endmodule

`default_nettype wire

// File: src/dispatch_ctrl.sv
// four-phase req/ack front end, issues one instruction per handshake
// inst must be stable while req is high; issue is valid only on the accept cycle
`default_nettype none

module dispatch_ctrl (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire ooo_pkg::inst_t     inst,
  input  wire logic               inst_req,
  output logic                    inst_ack,
  input  wire logic               srcs_ready,
  input  wire logic               free_empty,
  input  wire logic               rob_full,
  input  wire logic               alu_free,
  input  wire logic               mul_free,
  input  wire ooo_pkg::data_t     src1_value,
  input  wire ooo_pkg::data_t     src2_value,
  input  wire ooo_pkg::phys_idx_t new_tag,
  output logic                    alloc,
  output ooo_pkg::issue_t         issue
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    STALL = 2'd1,
    ACK   = 2'd2
  } state_t;

  state_t state;
  logic   unit_free;
  logic   go;

  // target unit by opcode
  assign unit_free = (inst.op == ooo_pkg::OP_MUL) ? mul_free : alu_free;

  // every resource reports its own readiness
  assign go = inst_req && srcs_ready && !free_empty && !rob_full && unit_free;

  // no accept while ack is still up
  assign alloc    = go && (state != ACK);
  assign inst_ack = (state == ACK);

  ////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (go) begin
            state <= ACK;
          end else if (inst_req) begin
            state <= STALL;
          end
        end
        // request pending, waiting on a resource
        STALL: begin
          if (go) begin
            state <= ACK;
          end
        end
        // hold ack until req drops
        ACK: begin
          if (!inst_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // operand b is the zero-extended immediate for OP_ADDI
  always_comb begin
    issue.valid = alloc;
    issue.op    = inst.op;
    issue.tag   = new_tag;
    issue.opa   = src1_value;
    if (inst.op == ooo_pkg::OP_ADDI) begin
      issue.opb = ooo_pkg::data_t'(inst.operand.imm);
    end else begin
      issue.opb = src2_value;
    end
  end

endmodule

`default_nettype wire

// File: src/free_list.sv
// circular FIFO of free phys tags, holds tags 8..15 after reset
// depth is phys minus arch regs, which bounds the tags ever free at once
`default_nettype none

module free_list (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               alloc,
  input  wire logic               release_valid,
  input  wire ooo_pkg::phys_idx_t release_tag,
  output ooo_pkg::phys_idx_t      head_tag,
  output logic                    free_empty
);

  ooo_pkg::phys_idx_t                  fifo [ooo_pkg::FREE_REGS];
  logic [ooo_pkg::FREE_IDX_W-1:0]      head;
  logic [ooo_pkg::FREE_IDX_W-1:0]      tail;
  logic [ooo_pkg::FREE_IDX_W:0]        count;

  assign head_tag   = fifo[head];
  assign free_empty = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ooo_pkg::FREE_REGS; i++) begin
        fifo[i] <= ooo_pkg::phys_idx_t'(ooo_pkg::NUM_ARCH_REGS + i);
      end
      head  <= '0;
      // full at reset, tail wraps back onto head
      tail  <= '0;
      count <= (ooo_pkg::FREE_IDX_W + 1)'(ooo_pkg::FREE_REGS);
    end else begin
      // pop on rename
      if (alloc) begin
        head <= head + 1'b1;
      end
      // push on retire
      if (release_valid) begin
        fifo[tail] <= release_tag;
        tail       <= tail + 1'b1;
      end
      // pop and push together leave count alone
      case ({alloc, release_valid})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/mul_unit.sv
// iterative shift-add multiplier, product wraps modulo 2^DATA_WIDTH
// step 0 runs in the capture cycle so done rises MUL_CYCLES after issue
`default_nettype none

module mul_unit (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire ooo_pkg::issue_t    issue,
  input  wire logic               grant,
  output logic                    mul_free,
  output logic                    done,
  output ooo_pkg::phys_idx_t      tag,
  output ooo_pkg::data_t          result
);

  typedef logic [$clog2(ooo_pkg::MUL_CYCLES):0] cnt_t;

  logic           busy;
  cnt_t           cnt;
  logic           capture;
  logic           step;
  ooo_pkg::data_t mcand;
  ooo_pkg::data_t mplier;
  ooo_pkg::data_t acc;
  ooo_pkg::data_t src_a;
  ooo_pkg::data_t src_b;
  ooo_pkg::data_t src_acc;

  assign capture  = issue.valid && (issue.op == ooo_pkg::OP_MUL);
  assign done     = busy && (cnt == cnt_t'(ooo_pkg::MUL_CYCLES));
  assign step     = capture || (busy && !done);
  assign mul_free = !busy;
  assign result   = acc;

  // step inputs, fresh operands on capture
  assign src_a   = capture ? issue.opa : mcand;
  assign src_b   = capture ? issue.opb : mplier;
  assign src_acc = capture ? '0 : acc;

  // control, bit counter
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (capture) begin
      busy <= 1'b1;
      cnt  <= cnt_t'(1);
    end else if (done && grant) begin
      busy <= 1'b0;
    end else if (step) begin
      cnt <= cnt + 1'b1;
    end
  end

  // datapath, one partial product per step
  always_ff @(posedge clock) begin
    if (capture) begin
      tag <= issue.tag;
    end
    if (step) begin
      acc    <= src_acc + (src_b[0] ? src_a : '0);
      mcand  <= src_a << 1;
      mplier <= src_b >> 1;
    end
  end

endmodule

`default_nettype wire

// File: src/ooo_core.sv
// rename core top, in-order issue and in-order retire
// inst_req/inst_ack is a four-phase handshake; commit has no back-pressure
`default_nettype none

module ooo_core (
  input  wire logic           clock,
  input  wire logic           reset,
  input  wire ooo_pkg::inst_t inst,
  input  wire logic           inst_req,
  output logic                inst_ack,
  output ooo_pkg::commit_t    commit
);

  // dispatch side
  logic               alloc;
  logic               srcs_ready;
  logic               free_empty;
  logic               rob_full;
  ooo_pkg::phys_idx_t new_tag;
  ooo_pkg::phys_idx_t src1_tag;
  ooo_pkg::phys_idx_t src2_tag;
  ooo_pkg::phys_idx_t old_tag;
  ooo_pkg::data_t     src1_value;
  ooo_pkg::data_t     src2_value;
  ooo_pkg::issue_t    issue;

  // execute and complete
  logic               alu_free;
  logic               mul_free;
  logic               mul_done;
  logic               mul_grant;
  ooo_pkg::phys_idx_t mul_tag;
  ooo_pkg::data_t     mul_result;
  ooo_pkg::cdb_t      cdb;

  // retire
  ooo_pkg::phys_idx_t rob_head_tag;
  ooo_pkg::data_t     rob_head_value;
  logic               release_valid;
  ooo_pkg::phys_idx_t release_tag;

  dispatch_ctrl u_dispatch (
    .clock, .reset, .inst, .inst_req, .inst_ack,
    .srcs_ready, .free_empty, .rob_full, .alu_free, .mul_free,
    .src1_value, .src2_value, .new_tag, .alloc, .issue
  );

  rename_map u_map (
    .clock, .reset, .inst, .alloc, .new_tag, .cdb,
    .src1_tag, .src2_tag, .old_tag, .srcs_ready
  );

  free_list u_free (
    .clock, .reset, .alloc, .release_valid, .release_tag,
    .head_tag (new_tag),
    .free_empty
  );

  reorder_buffer u_rob (
    .clock, .reset, .alloc,
    .dest       (inst.dest),
    .new_tag, .old_tag, .cdb,
    .head_tag   (rob_head_tag),
    .head_value (rob_head_value),
    .rob_full, .release_valid, .release_tag, .commit
  );

  // rd3 serves the retiring entry
  phys_regfile u_regfile (
    .clock, .reset, .cdb,
    .rd1_tag (src1_tag), .rd2_tag (src2_tag), .rd3_tag (rob_head_tag),
    .rd1_value (src1_value), .rd2_value (src2_value), .rd3_value (rob_head_value)
  );

  mul_unit u_mul (
    .clock, .reset, .issue,
    .grant (mul_grant), .mul_free,
    .done (mul_done), .tag (mul_tag), .result (mul_result)
  );

  complete_stage u_complete (
    .clock, .reset, .issue,
    .mul_done, .mul_tag, .mul_result, .mul_grant, .alu_free, .cdb
  );

endmodule

`default_nettype wire

// File: src/ooo_pkg.sv
// shared sizes, opcodes and bus structs for the rename core
// sizes are fixed here; the free list depth follows from phys minus arch
`default_nettype none

package ooo_pkg;

  // machine sizes
  localparam int NUM_ARCH_REGS = 8;
  localparam int NUM_PHYS_REGS = 16;
  localparam int FREE_REGS     = NUM_PHYS_REGS - NUM_ARCH_REGS;
  localparam int FREE_IDX_W    = $clog2(FREE_REGS);
  localparam int ROB_SIZE      = 8;
  localparam int ROB_IDX_W     = $clog2(ROB_SIZE);
  localparam int DATA_WIDTH    = 16;
  // one partial product per cycle
  localparam int MUL_CYCLES    = DATA_WIDTH;

  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_idx_t;
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_idx_t;
  typedef logic [DATA_WIDTH-1:0]            data_t;
  // msb is the wrap bit
  typedef logic [ROB_IDX_W:0]               rob_ptr_t;

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_ADDI = 2'd2,
    OP_MUL  = 2'd3
  } op_e;

  // second operand field, register view unless op is OP_ADDI
  typedef union packed {
    struct packed {
      arch_idx_t  src2;
      logic [4:0] pad;
    } reg_view;
    logic [7:0] imm;
  } operand_u;

  typedef struct packed {
    op_e       op;
    arch_idx_t dest;
    arch_idx_t src1;
    operand_u  operand;
  } inst_t;

  typedef struct packed {
    logic      valid;
    op_e       op;
    phys_idx_t tag;
    data_t     opa;
    data_t     opb;
  } issue_t;

  typedef struct packed {
    logic      valid;
    phys_idx_t tag;
    data_t     value;
  } cdb_t;

  typedef struct packed {
    logic      valid;
    arch_idx_t dest;
    data_t     value;
  } commit_t;

endpackage

`default_nettype wire

// File: src/phys_regfile.sv
// physical registers, written from the CDB, three async read ports
// a read of the tag being written returns the old value
`default_nettype none

module phys_regfile (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire ooo_pkg::cdb_t      cdb,
  input  wire ooo_pkg::phys_idx_t rd1_tag,
  input  wire ooo_pkg::phys_idx_t rd2_tag,
  input  wire ooo_pkg::phys_idx_t rd3_tag,
  output ooo_pkg::data_t          rd1_value,
  output ooo_pkg::data_t          rd2_value,
  output ooo_pkg::data_t          rd3_value
);

  ooo_pkg::data_t regs [ooo_pkg::NUM_PHYS_REGS];

  // two dispatch sources, one retire read
  assign rd1_value = regs[rd1_tag];
  assign rd2_value = regs[rd2_tag];
  assign rd3_value = regs[rd3_tag];

  always_ff @(posedge clock) begin
    if (reset) begin
      // arch state starts at zero
      for (int i = 0; i < ooo_pkg::NUM_PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (cdb.valid) begin
      regs[cdb.tag] <= cdb.value;
    end
  end

endmodule

`default_nettype wire

// File: src/rename_map.sv
// arch to phys map plus one ready bit per phys register
// lookups are combinational; ready bits change only at the clock edge
`default_nettype none

module rename_map (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire ooo_pkg::inst_t     inst,
  input  wire logic               alloc,
  input  wire ooo_pkg::phys_idx_t new_tag,
  input  wire ooo_pkg::cdb_t      cdb,
  output ooo_pkg::phys_idx_t      src1_tag,
  output ooo_pkg::phys_idx_t      src2_tag,
  output ooo_pkg::phys_idx_t      old_tag,
  output logic                    srcs_ready
);

  ooo_pkg::phys_idx_t                  map   [ooo_pkg::NUM_ARCH_REGS];
  logic [ooo_pkg::NUM_PHYS_REGS-1:0]   ready;
  logic                                src2_ok;

  // source lookup
  assign src1_tag = map[inst.src1];
  assign src2_tag = map[inst.operand.reg_view.src2];
  // previous mapping of dest, retired later by the ROB
  assign old_tag  = map[inst.dest];

  // immediate form has no second source
  assign src2_ok    = (inst.op == ooo_pkg::OP_ADDI) || ready[src2_tag];
  assign srcs_ready = ready[src1_tag] && src2_ok;

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
        map[i] <= ooo_pkg::phys_idx_t'(i);
      end
      ready <= '1;
    end else begin
      // result broadcast
      if (cdb.valid) begin
        ready[cdb.tag] <= 1'b1;
      end
      // rename dest, new tag waits for its result
      if (alloc) begin
        map[inst.dest] <= new_tag;
        ready[new_tag] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/reorder_buffer.sv
// in-order retire queue, entries completed by tag match on the CDB
// commit and tag release are combinational from the head entry
// head_value must be the regfile read of head_tag
`default_nettype none

module reorder_buffer (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               alloc,
  input  wire ooo_pkg::arch_idx_t dest,
  input  wire ooo_pkg::phys_idx_t new_tag,
  input  wire ooo_pkg::phys_idx_t old_tag,
  input  wire ooo_pkg::cdb_t      cdb,
  output ooo_pkg::phys_idx_t      head_tag,
  input  wire ooo_pkg::data_t     head_value,
  output logic                    rob_full,
  output logic                    release_valid,
  output ooo_pkg::phys_idx_t      release_tag,
  output ooo_pkg::commit_t        commit
);

  localparam int W = ooo_pkg::ROB_IDX_W;

  // entry payload
  ooo_pkg::arch_idx_t           ent_dest [ooo_pkg::ROB_SIZE];
  ooo_pkg::phys_idx_t           ent_new  [ooo_pkg::ROB_SIZE];
  ooo_pkg::phys_idx_t           ent_old  [ooo_pkg::ROB_SIZE];
  logic [ooo_pkg::ROB_SIZE-1:0] ent_done;

  ooo_pkg::rob_ptr_t head;
  ooo_pkg::rob_ptr_t tail;
  logic              rob_empty;
  logic              retire;

  // wrap bit tells full from empty
  assign rob_empty = (head == tail);
  assign rob_full  = (head[W-1:0] == tail[W-1:0]) && (head[W] != tail[W]);

  assign head_tag = ent_new[head[W-1:0]];
  assign retire   = !rob_empty && ent_done[head[W-1:0]];

  // old mapping goes back to the free list
  assign release_valid = retire;
  assign release_tag   = ent_old[head[W-1:0]];

  always_comb begin
    commit.valid = retire;
    commit.dest  = ent_dest[head[W-1:0]];
    commit.value = head_value;
  end

  ////////////////////////////////////////////////////////////
  // pointers and completion
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      ent_done <= '0;
    end else begin
      // stale slots may match, alloc clears them below
      if (cdb.valid) begin
        for (int i = 0; i < ooo_pkg::ROB_SIZE; i++) begin
          if (ent_new[i] == cdb.tag) begin
            ent_done[i] <= 1'b1;
          end
        end
      end
      if (alloc) begin
        ent_done[tail[W-1:0]] <= 1'b0;
        tail                  <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
    end
  end

  // payload written at the tail
  always_ff @(posedge clock) begin
    if (alloc) begin
      ent_dest[tail[W-1:0]] <= dest;
      ent_new[tail[W-1:0]]  <= new_tag;
      ent_old[tail[W-1:0]]  <= old_tag;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_ooo_core.sv
// testbench for the rename core, in-order reference model on arch registers
// inputs change 2 units after the rising edge, outputs sampled on the falling edge
// every wait is bounded; a timeout ends the remaining tests early
`default_nettype none

module tb_ooo_core;

  logic             clock;
  logic             reset;
  ooo_pkg::inst_t   inst;
  logic             inst_req;
  logic             inst_ack;
  ooo_pkg::commit_t commit;

  // reference model and expected commits in program order
  ooo_pkg::data_t   arch_model [ooo_pkg::NUM_ARCH_REGS];
  ooo_pkg::commit_t expected_q [$];
  ooo_pkg::commit_t exp_commit;

  logic [31:0] lfsr_state;
  int          errors;
  int          hs_errors;
  int          checked;
  int          sent;
  int          tests_run;
  int          tests_failed;
  int          mark;
  logic        timed_out;
  logic        prev_req;
  logic        prev_ack;
  logic [15:0] gap;

  ooo_core u_dut (
    .clock, .reset, .inst, .inst_req, .inst_ack, .commit
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////
  // 32-bit galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v          = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // b is the immediate for OP_ADDI, else the source 2 index
  function automatic ooo_pkg::inst_t make_inst(input ooo_pkg::op_e op, input int dest,
                                               input int src1, input int b);
    ooo_pkg::inst_t i;
    i.op   = op;
    i.dest = ooo_pkg::arch_idx_t'(dest);
    i.src1 = ooo_pkg::arch_idx_t'(src1);
    if (op == ooo_pkg::OP_ADDI) begin
      i.operand.imm = 8'(b);
    end else begin
      i.operand.reg_view.src2 = ooo_pkg::arch_idx_t'(b);
      i.operand.reg_view.pad  = '0;
    end
    return i;
  endfunction

  function automatic ooo_pkg::inst_t random_inst();
    logic [15:0]  op_bits;
    logic [15:0]  dest;
    logic [15:0]  src1;
    logic [15:0]  b;
    ooo_pkg::op_e op;
    op_bits = rand_bits(2);
    dest    = rand_bits(3);
    src1    = rand_bits(3);
    op      = ooo_pkg::op_e'(op_bits[1:0]);
    // 8 immediate bits or a 3-bit register
    if (op == ooo_pkg::OP_ADDI) begin
      b = rand_bits(8);
    end else begin
      b = rand_bits(3);
    end
    return make_inst(op, int'(dest), int'(src1), int'(b));
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  // wide math, low 16 bits kept so everything wraps mod 2^16
  function automatic ooo_pkg::commit_t ref_exec(input ooo_pkg::inst_t i);
    ooo_pkg::commit_t c;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      r;
    a = {16'd0, arch_model[i.src1]};
    if (i.op == ooo_pkg::OP_ADDI) begin
      b = {24'd0, i.operand.imm};
    end else begin
      b = {16'd0, arch_model[i.operand.reg_view.src2]};
    end
    case (i.op)
      ooo_pkg::OP_SUB: r = a - b;
      ooo_pkg::OP_MUL: r = a * b;
      default:         r = a + b;
    endcase
    arch_model[i.dest] = r[15:0];
    c.valid = 1'b1;
    c.dest  = i.dest;
    c.value = r[15:0];
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////
  task automatic idle_cycles(input int k);
    repeat (k) begin
      @(posedge clock);
      #2;
    end
  endtask

  // full four-phase handshake for one instruction
  task automatic send_inst(input ooo_pkg::inst_t i);
    int n;
    if (!timed_out) begin
      expected_q.push_back(ref_exec(i));
      inst     = i;
      inst_req = 1'b1;
      n        = 0;
      while (!inst_ack && !timed_out) begin
        if (n >= 500) begin
          $display("timeout at %0t: inst_ack never rose for instruction %0d", $time, sent);
          timed_out = 1'b1;
        end else begin
          @(posedge clock);
          #2;
          n++;
        end
      end
      // req held one more cycle, ack has to stay up meanwhile
      if (!timed_out) begin
        @(posedge clock);
        #2;
      end
      inst_req = 1'b0;
      n        = 0;
      // next req only once ack is low again
      while (inst_ack && !timed_out) begin
        if (n >= 500) begin
          $display("timeout at %0t: inst_ack stuck high after req dropped", $time);
          timed_out = 1'b1;
        end else begin
          @(posedge clock);
          #2;
          n++;
        end
      end
      sent++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expected_q.size() != 0 && !timed_out) begin
      if (n >= 1000) begin
        $display("timeout at %0t: %0d commits never arrived", $time, expected_q.size());
        timed_out = 1'b1;
      end else begin
        @(posedge clock);
        #2;
        n++;
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    tests_run++;
    if (errs == 0 && !timed_out) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", num, name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // commit compare and handshake monitor
  ////////////////////////////////////////////////////////////
  always @(negedge clock) begin
    if (!reset) begin
      if (commit.valid) begin
        if (expected_q.size() == 0) begin
          $display("unexpected commit at %0t with no instruction outstanding", $time);
          errors++;
        end else begin
          exp_commit = expected_q.pop_front();
          checked++;
          if (commit.dest != exp_commit.dest) begin
            $display("FAIL t=%0t commit.dest expected %0d got %0d",
                     $time, exp_commit.dest, commit.dest);
            errors++;
          end
          if (commit.value != exp_commit.value) begin
            $display("FAIL t=%0t commit.value expected %h got %h",
                     $time, exp_commit.value, commit.value);
            errors++;
          end
        end
      end
      // ack may only rise after req was seen high
      if (inst_ack && !prev_ack && !prev_req) begin
        $display("handshake error at %0t: inst_ack rose while inst_req was low", $time);
        errors++;
        hs_errors++;
      end
      // ack may only fall after req was seen low
      if (!inst_ack && prev_ack && prev_req) begin
        $display("handshake error at %0t: inst_ack fell while inst_req was high", $time);
        errors++;
        hs_errors++;
      end
    end
    prev_req = inst_req;
    prev_ack = inst_ack;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    reset        = 1'b1;
    inst_req     = 1'b0;
    inst         = '0;
    lfsr_state   = 32'd66360;
    errors       = 0;
    hs_errors    = 0;
    checked      = 0;
    sent         = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    prev_req     = 1'b0;
    prev_ack     = 1'b0;
    // model matches the reset state, all zero
    for (int r = 0; r < ooo_pkg::NUM_ARCH_REGS; r++) begin
      arch_model[r] = '0;
    end
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;

    // quiet after reset
    mark = errors;
    repeat (10) begin
      @(posedge clock);
      #2;
      if (inst_ack) begin
        $display("FAIL t=%0t inst_ack expected 0 got 1", $time);
        errors++;
      end
      if (commit.valid) begin
        $display("FAIL t=%0t commit.valid expected 0 got 1", $time);
        errors++;
      end
    end
    report_test(1, "reset quiet", errors - mark);

    // dependent alu chain, r4 and r5 wrap below zero
    mark = errors;
    send_inst(make_inst(ooo_pkg::OP_ADDI, 1, 0, 200));
    send_inst(make_inst(ooo_pkg::OP_ADDI, 2, 1, 255));
    send_inst(make_inst(ooo_pkg::OP_ADD,  3, 1, 2));
    send_inst(make_inst(ooo_pkg::OP_SUB,  4, 0, 3));
    send_inst(make_inst(ooo_pkg::OP_ADD,  5, 4, 4));
    send_inst(make_inst(ooo_pkg::OP_SUB,  1, 1, 2));
    send_inst(make_inst(ooo_pkg::OP_ADDI, 1, 1, 1));
    send_inst(make_inst(ooo_pkg::OP_ADD,  2, 2, 2));
    wait_drain();
    report_test(2, "alu chain", errors - mark);

    // multiply, independent alu ops overtake it, then a consumer
    mark = errors;
    send_inst(make_inst(ooo_pkg::OP_MUL,  6, 3, 4));
    send_inst(make_inst(ooo_pkg::OP_ADDI, 7, 0, 9));
    send_inst(make_inst(ooo_pkg::OP_ADD,  0, 7, 7));
    send_inst(make_inst(ooo_pkg::OP_SUB,  2, 7, 5));
    send_inst(make_inst(ooo_pkg::OP_ADD,  1, 6, 7));
    wait_drain();
    report_test(3, "mul with overtaking alu", errors - mark);

    // random stream, far more than the 8 free tags
    mark = errors;
    for (int k = 0; k < 200; k++) begin
      gap = rand_bits(2);
      idle_cycles(int'(gap));
      send_inst(random_inst());
    end
    wait_drain();
    report_test(5, "random stream", errors - mark);

    // handshake monitor ran over the whole run
    report_test(4, "handshake rules", hs_errors);

    $display("tests %0d, failed %0d, sent %0d, commits checked %0d, errors %0d",
             tests_run, tests_failed, sent, checked, errors);
    if (errors == 0 && !timed_out && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/ooo_pkg.sv
src/dispatch_ctrl.sv
src/rename_map.sv
src/free_list.sv
src/reorder_buffer.sv
src/phys_regfile.sv
src/mul_unit.sv
src/complete_stage.sv
src/ooo_core.sv
tests/tb_ooo_core.sv
